// ==== src/soc_pkg.sv ====
package soc_pkg;

  // Bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int STRB_W = 4;
  localparam int LANE_W = DATA_W / STRB_W;

  // Region field in the top address bits
  localparam int REGION_W = 16;
  localparam int REGION_LSB = ADDR_W - REGION_W;

  localparam logic [REGION_W-1:0] TEXT_REGION = 16'h0000;
  localparam logic [REGION_W-1:0] HEAP_REGION = 16'h0001;
  localparam logic [REGION_W-1:0] LED_REGION = 16'h8001;

  // Bank geometry, bank in addr[15:14] and word in addr[13:2]
  localparam int BANK_COUNT = 4;
  localparam int BANK_WORDS = 4096;
  localparam int BANK_SEL_W = $clog2(BANK_COUNT);
  localparam int WORD_W = $clog2(BANK_WORDS);
  localparam int WORD_LSB = $clog2(STRB_W);
  localparam int BANK_LSB = WORD_LSB + WORD_W;

  // LED register, word offset 0x10 is byte offset 0x40
  localparam int LED_W = 4;
  localparam int LED_WORD_W = REGION_LSB - WORD_LSB;
  localparam logic [LED_WORD_W-1:0] LED_WORD = 14'h0010;

  // Nonzero wstrb marks a write
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic              ready;
    logic [DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== src/ram_bank.sv ====
module ram_bank (
  input  logic                       clk,
  input  logic                       en,
  input  logic [soc_pkg::WORD_W-1:0] word,
  input  logic [soc_pkg::DATA_W-1:0] wdata,
  input  logic [soc_pkg::STRB_W-1:0] wstrb,
  output logic [soc_pkg::DATA_W-1:0] rdata
);

  logic [soc_pkg::DATA_W-1:0] lane_rd;

  for (genvar i = 0; i < soc_pkg::STRB_W; i++) begin : g_lane
    logic [soc_pkg::LANE_W-1:0] mem [soc_pkg::BANK_WORDS];
    logic [soc_pkg::LANE_W-1:0] dout;

    // Write-first, a written lane returns the new byte
    always_ff @(posedge clk) begin
      if (en) begin
        if (wstrb[i]) begin
          mem[word] <= wdata[i*soc_pkg::LANE_W +: soc_pkg::LANE_W];
          dout <= wdata[i*soc_pkg::LANE_W +: soc_pkg::LANE_W];
        end else begin
          dout <= mem[word];
        end
      end
    end

    assign lane_rd[i*soc_pkg::LANE_W +: soc_pkg::LANE_W] = dout;
  end

  // Output stage for a fixed two-cycle read latency
  always_ff @(posedge clk) begin
    if (en) begin
      rdata <= lane_rd;
    end
  end

endmodule

// ==== src/banked_ram.sv ====
module banked_ram (
  input  logic              clk,
  input  logic              resetn,
  input  logic              valid,
  input  soc_pkg::mem_req_t req,
  output soc_pkg::mem_rsp_t rsp
);

  logic                           valid_q;
  logic                           start;
  logic                           stage1;
  logic                           stage2;
  logic                           ready_q;
  logic [soc_pkg::BANK_SEL_W-1:0] bank;
  logic [soc_pkg::BANK_SEL_W-1:0] bank_d1;
  logic [soc_pkg::BANK_SEL_W-1:0] bank_d2;
  logic [soc_pkg::WORD_W-1:0]     word;
  logic [soc_pkg::DATA_W-1:0]     bank_rdata [soc_pkg::BANK_COUNT];
  logic [soc_pkg::DATA_W-1:0]     rdata_q;

  // New transaction on the first valid cycle after a low one
  assign start = valid && !valid_q;
  assign bank = req.addr[soc_pkg::BANK_LSB +: soc_pkg::BANK_SEL_W];
  assign word = req.addr[soc_pkg::WORD_LSB +: soc_pkg::WORD_W];

  for (genvar b = 0; b < soc_pkg::BANK_COUNT; b++) begin : g_bank
    logic [soc_pkg::STRB_W-1:0] bank_wstrb;

    // Strobes reach only the addressed bank, and only once
    assign bank_wstrb = (start && bank == soc_pkg::BANK_SEL_W'(b)) ? req.wstrb : '0;

    ram_bank u_bank (
      .clk   (clk),
      .en    (valid),
      .word  (word),
      .wdata (req.wdata),
      .wstrb (bank_wstrb),
      .rdata (bank_rdata[b])
    );
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= 1'b0;
      stage1  <= 1'b0;
      stage2  <= 1'b0;
      ready_q <= 1'b0;
    end else begin
      valid_q <= valid;
      stage1  <= start;
      stage2  <= stage1;
      // Writes answer one stage early
      ready_q <= (|req.wstrb) ? stage1 : stage2;
    end
  end

  // Bank index follows the two-stage bank read
  always_ff @(posedge clk) begin
    bank_d1 <= bank;
    bank_d2 <= bank_d1;
    rdata_q <= bank_rdata[bank_d2];
  end

  assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== src/led_port.sv ====
module led_port (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      valid,
  input  soc_pkg::mem_req_t         req,
  output soc_pkg::mem_rsp_t         rsp,
  output logic [soc_pkg::LED_W-1:0] led
);

  logic                       valid_q;
  logic                       start;
  logic                       hit;
  logic                       ready_q;
  logic [soc_pkg::DATA_W-1:0] rdata_q;

  assign start = valid && !valid_q;
  assign hit = req.addr[soc_pkg::WORD_LSB +: soc_pkg::LED_WORD_W] == soc_pkg::LED_WORD;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      valid_q <= 1'b0;
      ready_q <= 1'b0;
      led     <= '0;
    end else begin
      valid_q <= valid;
      ready_q <= start;
      // Only a full-word write loads the LEDs
      if (start && hit && req.wstrb == '1) begin
        led <= req.wdata[soc_pkg::LED_W-1:0];
      end
    end
  end

  // Other offsets read as zero
  always_ff @(posedge clk) begin
    if (start) begin
      rdata_q <= hit ? soc_pkg::DATA_W'(led) : '0;
    end
  end

  assign rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== src/bus_decoder.sv ====
module bus_decoder (
  input  logic              clk,
  input  logic              resetn,
  input  logic              mem_valid,
  input  soc_pkg::mem_req_t mem_req,
  output soc_pkg::mem_rsp_t mem_rsp,
  output soc_pkg::mem_req_t tgt_req,
  output logic              text_valid,
  output logic              heap_valid,
  output logic              led_valid,
  input  soc_pkg::mem_rsp_t text_rsp,
  input  soc_pkg::mem_rsp_t heap_rsp,
  input  soc_pkg::mem_rsp_t led_rsp
);

  logic [soc_pkg::REGION_W-1:0] region;
  logic                         rsp_ready;
  logic [soc_pkg::DATA_W-1:0]   rsp_rdata;
  logic                         ready_q;
  logic [soc_pkg::DATA_W-1:0]   rdata_q;

  assign region = mem_req.addr[soc_pkg::REGION_LSB +: soc_pkg::REGION_W];

  // Request register shared by all targets
  always_ff @(posedge clk) begin
    tgt_req <= mem_req;
  end

  // One registered valid per region
  always_ff @(posedge clk) begin
    if (!resetn) begin
      text_valid <= 1'b0;
      heap_valid <= 1'b0;
      led_valid  <= 1'b0;
    end else begin
      text_valid <= mem_valid && (region == soc_pkg::TEXT_REGION);
      heap_valid <= mem_valid && (region == soc_pkg::HEAP_REGION);
      led_valid  <= mem_valid && (region == soc_pkg::LED_REGION);
    end
  end

  // Only one target answers at a time
  always_comb begin
    rsp_ready = text_rsp.ready | heap_rsp.ready | led_rsp.ready;
    if (text_rsp.ready) begin
      rsp_rdata = text_rsp.rdata;
    end else if (heap_rsp.ready) begin
      rsp_rdata = heap_rsp.rdata;
    end else if (led_rsp.ready) begin
      rsp_rdata = led_rsp.rdata;
    end else begin
      rsp_rdata = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= rsp_ready;
    end
  end

  always_ff @(posedge clk) begin
    rdata_q <= rsp_rdata;
  end

  assign mem_rsp = '{ready: ready_q, rdata: rdata_q};

endmodule

// ==== src/soc_memory_top.sv ====
module soc_memory_top (
  input  logic                      clk,
  input  logic                      resetn,
  input  logic                      mem_valid,
  input  soc_pkg::mem_req_t         mem_req,
  output soc_pkg::mem_rsp_t         mem_rsp,
  output logic [soc_pkg::LED_W-1:0] led
);

  soc_pkg::mem_req_t tgt_req;
  logic              text_valid;
  logic              heap_valid;
  logic              led_valid;
  soc_pkg::mem_rsp_t text_rsp;
  soc_pkg::mem_rsp_t heap_rsp;
  soc_pkg::mem_rsp_t led_rsp;

  bus_decoder u_decoder (
    .clk        (clk),
    .resetn     (resetn),
    .mem_valid  (mem_valid),
    .mem_req    (mem_req),
    .mem_rsp    (mem_rsp),
    .tgt_req    (tgt_req),
    .text_valid (text_valid),
    .heap_valid (heap_valid),
    .led_valid  (led_valid),
    .text_rsp   (text_rsp),
    .heap_rsp   (heap_rsp),
    .led_rsp    (led_rsp)
  );

  // Region 0x0000
  banked_ram text_ram (
    .clk    (clk),
    .resetn (resetn),
    .valid  (text_valid),
    .req    (tgt_req),
    .rsp    (text_rsp)
  );

  // Region 0x0001
  banked_ram heap_ram (
    .clk    (clk),
    .resetn (resetn),
    .valid  (heap_valid),
    .req    (tgt_req),
    .rsp    (heap_rsp)
  );

  led_port u_led (
    .clk    (clk),
    .resetn (resetn),
    .valid  (led_valid),
    .req    (tgt_req),
    .rsp    (led_rsp),
    .led    (led)
  );

endmodule

// ==== tests/soc_checker.sv ====
module soc_checker (
  input logic                      clk,
  input logic                      resetn,
  input logic                      mem_valid,
  input soc_pkg::mem_rsp_t         mem_rsp,
  input logic [soc_pkg::LED_W-1:0] led
);

  // Ready is a single-cycle pulse
  property ready_is_pulse;
    @(posedge clk) disable iff (!resetn)
      mem_rsp.ready |=> !mem_rsp.ready;
  endproperty

  property ready_needs_valid;
    @(posedge clk) disable iff (!resetn)
      mem_rsp.ready |-> mem_valid;
  endproperty

  // An LED change is answered by the top-level ready one cycle later
  property led_moves_on_ready;
    @(posedge clk) disable iff (!resetn)
      (led != $past(led)) |=> mem_rsp.ready;
  endproperty

  ready_pulse_a: assert property (ready_is_pulse)
    else $error("mem_rsp.ready stayed high for two cycles");

  ready_valid_a: assert property (ready_needs_valid)
    else $error("mem_rsp.ready high while mem_valid is low");

  led_change_a: assert property (led_moves_on_ready)
    else $error("led changed without a following ready pulse");

endmodule

// ==== tests/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic resetn
);

  localparam int HALF_PERIOD = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Reset held low for two rising edges
  initial begin
    resetn = 1'b0;
    repeat (2) @(posedge clk);
    resetn <= 1'b1;
  end

endmodule

// ==== tests/tb_soc.sv ====
module tb_soc;

  localparam int LINE_CYCLES = 40;
  localparam int READY_LIMIT = 20;

  typedef struct packed {
    logic        is_write;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic [31:0] exp_rdata;
    logic [3:0]  exp_led;
  } stim_t;

  logic                      clk;
  logic                      resetn;
  logic                      mem_valid;
  soc_pkg::mem_req_t         mem_req;
  soc_pkg::mem_rsp_t         mem_rsp;
  logic [soc_pkg::LED_W-1:0] led;

  stim_t vectors[$];
  int    errors;
  int    checks;
  int    limit_cycles;

  tb_clock clock_gen (
    .clk    (clk),
    .resetn (resetn)
  );

  soc_memory_top dut0 (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_req   (mem_req),
    .mem_rsp   (mem_rsp),
    .led       (led)
  );

  bind soc_memory_top soc_checker checker0 (
    .clk       (clk),
    .resetn    (resetn),
    .mem_valid (mem_valid),
    .mem_rsp   (mem_rsp),
    .led       (led)
  );

  task automatic compare_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
    checks++;
    if (got !== expected) begin
      errors++;
      $display("[FAIL] %0t: %s got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic load_stim();
    int          fd;
    int          n;
    string       line;
    logic [7:0]  op;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic [3:0]  wstrb;
    logic [3:0]  led_val;
    fd = $fopen("tests/soc_stim.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("Could not open tests/soc_stim.txt");
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 1 && line[0] != "#") begin
          n = $sscanf(line, "%c %h %h %h %h %h", op, addr, wdata, wstrb, rdata, led_val);
          if (n == 6 && (op == "W" || op == "R")) begin
            vectors.push_back('{op == "W", addr, wdata, wstrb, rdata, led_val});
          end else begin
            errors++;
            $display("Malformed stim line: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic run_transaction(input stim_t v, input int index);
    int    cycles;
    int    expected_cycles;
    string tag;
    tag = $sformatf("vector %0d (%s %h)", index, v.is_write ? "W" : "R", v.addr);
    // Decoder adds two cycles around each target's own latency
    if (v.addr[31:16] == soc_pkg::LED_REGION) begin
      expected_cycles = 3;
    end else if (v.is_write) begin
      expected_cycles = 4;
    end else begin
      expected_cycles = 5;
    end
    @(posedge clk);
    mem_valid <= 1'b1;
    mem_req   <= '{addr: v.addr, wdata: v.wdata, wstrb: v.is_write ? v.wstrb : 4'h0};
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
      @(negedge clk);
    end while (!mem_rsp.ready && cycles < READY_LIMIT);
    if (!mem_rsp.ready) begin
      errors++;
      $display("Timeout: no ready within %0d cycles for %s", READY_LIMIT, tag);
    end else begin
      compare_value({tag, " latency"}, 32'(cycles), 32'(expected_cycles));
      if (!v.is_write) begin
        compare_value({tag, " rdata"}, mem_rsp.rdata, v.exp_rdata);
      end
      compare_value({tag, " led"}, 32'(led), 32'(v.exp_led));
    end
    @(posedge clk);
    mem_valid <= 1'b0;
  endtask

  initial begin
    mem_valid    = 1'b0;
    mem_req      = '0;
    errors       = 0;
    checks       = 0;
    limit_cycles = 0;
    load_stim();
    limit_cycles = vectors.size() * LINE_CYCLES + 10;
    wait (resetn === 1'b1);
    @(negedge clk);
    compare_value("led after reset", 32'(led), 32'h0);
    compare_value("ready after reset", 32'(mem_rsp.ready), 32'h0);
    foreach (vectors[i]) begin
      run_transaction(vectors[i], i);
    end
    repeat (2) @(posedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, run stopped", limit_cycles);
    $display("Errors found");
    $finish;
  end

endmodule

// ==== files.f ====
src/soc_pkg.sv
src/ram_bank.sv
src/banked_ram.sv
src/led_port.sv
src/bus_decoder.sv
src/soc_memory_top.sv
tests/soc_checker.sv
tests/tb_clock.sv
tests/tb_soc.sv

// ==== tests/soc_stim.txt ====
# op addr wdata wstrb exp_rdata exp_led, all hex
# exp_rdata is checked on reads only, exp_led is the LED value after the access
W 00000010 11223344 f 00000000 0
W 00010010 a5a5a5a5 f 00000000 0
W 00004020 cafef00d f 00000000 0
W 0001c040 0badbeef f 00000000 0
W 00008030 12345678 f 00000000 0
R 00000010 00000000 0 11223344 0
R 00010010 00000000 0 a5a5a5a5 0
R 00004020 00000000 0 cafef00d 0
R 0001c040 00000000 0 0badbeef 0
W 00008030 aabbccdd 5 00000000 0
R 00008030 00000000 0 12bb56dd 0
W 80010040 0000000a f 00000000 a
R 80010040 00000000 0 0000000a a
W 80010040 00000005 3 00000000 a
W 80010044 00000003 f 00000000 a
R 80010044 00000000 0 00000000 a
